//--- common/trs_io_config.svh
`ifndef TRS_IO_CONFIG_SVH
`define TRS_IO_CONFIG_SVH

// identity replies
`define TRS_IO_COOKIE          8'hAF
`define TRS_IO_VERSION_MAJOR   3'd0
`define TRS_IO_VERSION_MINOR   5'd3

// z80 i/o ports
`define TRS_IO_PORT            8'h1F
`define TRS_IO_FREHD_NIBBLE    4'hC   // hard-disk ports C0h..CFh
`define TRS_IO_SPI_CTRL_PORT   8'hFC
`define TRS_IO_SPI_DATA_PORT   8'hFD

// timing, in system clocks
`define TRS_IO_ESP_REQ_CYCLES  50
`define TRS_IO_SYNC_STAGES     2      // every async input
`define TRS_IO_FLASH_BIT_CYCLES 16    // one flash sck period

`endif

//--- common/trs_io_pkg.sv
package trs_io_pkg;

  // opcodes sent by the co-processor, numbering kept from its firmware
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    dbus_read        = 8'd3,
    dbus_write       = 8'd4,
    get_version      = 8'd15,
    abus_read        = 8'd18,
    set_led          = 8'd26,
    get_config       = 8'd27,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31,
    set_esp_status   = 8'd32
  } cmd_op_t;

  typedef enum logic {
    idle,
    read_param
  } parser_state_t;

  // operation shown to the co-processor on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    none       = 4'd15
  } esp_op_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
    logic        rd_n;
    logic        wr_n;
    logic        in_n;
    logic        out_n;
  } z80_bus_t;

  typedef struct packed {
    logic       valid;
    cmd_op_t    op;
    logic [7:0] param;
  } cmd_action_t;

  typedef struct packed {
    logic       ctrl_we;   // one-cycle strobe
    logic       data_we;   // one-cycle strobe, starts a transfer
    logic [7:0] ctrl;
    logic [7:0] data;
  } flash_req_t;

endpackage

//--- hdl/z80_bus_decoder.sv
`timescale 1ns/1ps
`include "trs_io_config.svh"

module z80_bus_decoder (
  input  logic                    clk,
  input  logic                    reset,
  input  trs_io_pkg::z80_bus_t    bus,
  input  trs_io_pkg::cmd_action_t action,
  input  logic [7:0]              flash_rx,
  input  logic                    esp_done,
  output logic [7:0]              d_out,
  output logic                    d_oe,
  output logic                    wait_out,
  output logic                    esp_req,
  output trs_io_pkg::esp_op_t     esp_s,
  output trs_io_pkg::flash_req_t  z80_flash
);
  import trs_io_pkg::*;

  localparam int SYNC  = `TRS_IO_SYNC_STAGES;
  localparam int REQ_W = $clog2(`TRS_IO_ESP_REQ_CYCLES + 1);

  logic [SYNC-1:0]  strobe_sync;
  logic [SYNC-1:0]  done_sync;
  logic             strobe_q;
  logic             done_q;
  logic             strobe;
  logic             io_access;
  logic             done_rise;
  logic [REQ_W-1:0] req_count;
  logic [7:0]       trs_data;    // byte the co-processor left for the next IN
  logic [7:0]       port;
  logic             io_port;
  logic             frehd_port;
  logic             esp_in;
  logic             esp_out;
  logic             spi_data_in;

  assign strobe = ~bus.rd_n | ~bus.wr_n | ~bus.in_n | ~bus.out_n;
  assign port   = bus.addr[7:0];

  assign io_port     = (port == `TRS_IO_PORT);
  assign frehd_port  = (port[7:4] == `TRS_IO_FREHD_NIBBLE);
  assign esp_in      = (io_port | frehd_port) & ~bus.in_n;
  assign esp_out     = (io_port | frehd_port) & ~bus.out_n;
  assign spi_data_in = (port == `TRS_IO_SPI_DATA_PORT) & ~bus.in_n;

  assign io_access = strobe_sync[SYNC-1] & ~strobe_q;  // start of any bus cycle
  assign done_rise = done_sync[SYNC-1] & ~done_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_sync <= '0;
      done_sync   <= '0;
      strobe_q    <= 1'b0;
      done_q      <= 1'b0;
      wait_out    <= 1'b0;
      req_count   <= '0;
    end else begin
      strobe_sync <= {strobe_sync[SYNC-2:0], strobe};
      done_sync   <= {done_sync[SYNC-2:0], esp_done};
      strobe_q    <= strobe_sync[SYNC-1];
      done_q      <= done_sync[SYNC-1];

      if (io_access && (esp_in || esp_out)) begin
        wait_out  <= 1'b1;  // hold the z80 until the co-processor answers
        req_count <= REQ_W'(`TRS_IO_ESP_REQ_CYCLES);
      end else begin
        if (done_rise)
          wait_out <= 1'b0;
        if (req_count != '0)
          req_count <= req_count - 1'b1;
      end
    end
  end

  assign esp_req = (req_count != '0);

  always_ff @(posedge clk) begin
    if (action.valid && action.op == dbus_write)
      trs_data <= action.param;
  end

  // operation code follows the strobe, no register
  always_comb begin
    esp_s = none;
    if (io_port && !bus.in_n)
      esp_s = trs_io_in;
    else if (io_port && !bus.out_n)
      esp_s = trs_io_out;
    else if (frehd_port && !bus.in_n)
      esp_s = frehd_in;
    else if (frehd_port && !bus.out_n)
      esp_s = frehd_out;
  end

  assign d_oe  = esp_in | spi_data_in;
  assign d_out = esp_in ? trs_data : (spi_data_in ? flash_rx : 8'h00);

  assign z80_flash.ctrl_we = io_access & (port == `TRS_IO_SPI_CTRL_PORT) & ~bus.out_n;
  assign z80_flash.data_we = io_access & (port == `TRS_IO_SPI_DATA_PORT) & ~bus.out_n;
  assign z80_flash.ctrl    = bus.data;
  assign z80_flash.data    = bus.data;

endmodule

//--- hdl/flash_spi_master.sv
`timescale 1ns/1ps
`include "trs_io_config.svh"

module flash_spi_master (
  input  logic                   clk,
  input  logic                   reset,
  input  trs_io_pkg::flash_req_t z80_req,
  input  trs_io_pkg::flash_req_t link_req,
  output logic [7:0]             flash_rx,
  output logic                   flash_cs_n,
  output logic                   flash_sck,
  output logic                   flash_si,
  input  logic                   flash_so
);
  import trs_io_pkg::*;

  localparam int HALF_W = $clog2(`TRS_IO_FLASH_BIT_CYCLES) - 1;  // sck bit in the counter
  localparam int CNT_W  = $clog2(8 * `TRS_IO_FLASH_BIT_CYCLES);

  logic [7:0]     ctrl_reg;    // bit 7 selects the flash
  logic [7:0]     shift_reg;
  logic [CNT_W:0] count;       // msb set while a transfer runs
  logic           busy;
  logic           phase_start;
  flash_req_t     req;

  // z80 wins a same-cycle collision
  assign req = (z80_req.ctrl_we || z80_req.data_we) ? z80_req : link_req;

  assign busy        = count[CNT_W];
  assign phase_start = (count[HALF_W-1:0] == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_reg <= 8'h00;
      count    <= '0;
      flash_si <= 1'b0;
    end else if (busy) begin
      count <= count + 1'b1;  // wraps to zero after the eighth bit
      if (phase_start && !count[HALF_W])
        flash_si <= shift_reg[7];  // sck low phase
    end else begin
      if (req.ctrl_we)
        ctrl_reg <= req.ctrl;
      if (req.data_we)
        count <= {1'b1, {CNT_W{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (busy && phase_start && count[HALF_W])
      shift_reg <= {shift_reg[6:0], flash_so};  // sample on the rising phase
    else if (!busy && req.data_we)
      shift_reg <= req.data;
  end

  assign flash_rx   = shift_reg;
  assign flash_cs_n = ~ctrl_reg[7];
  assign flash_sck  = count[HALF_W];

endmodule

//--- spi_link/spi_link_slave.sv
`timescale 1ns/1ps
`include "trs_io_config.svh"

module spi_link_slave (
  input  logic       clk,
  input  logic       reset,
  input  logic       sck,
  input  logic       mosi,
  input  logic       cs_n,
  output logic       miso,
  input  logic [7:0] tx_byte,
  output logic [7:0] rx_byte,
  output logic       byte_valid
);

  localparam int SYNC = `TRS_IO_SYNC_STAGES;

  logic [SYNC-1:0] sck_sync;
  logic [SYNC-1:0] mosi_sync;
  logic [SYNC-1:0] cs_sync;
  logic            sck_q;
  logic            sck_rise;
  logic            sck_fall;
  logic            active;
  logic [2:0]      bit_cnt;
  logic [7:0]      tx_shift;

  assign sck_rise = sck_sync[SYNC-1] & ~sck_q;
  assign sck_fall = ~sck_sync[SYNC-1] & sck_q;
  assign active   = ~cs_sync[SYNC-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_sync   <= '0;
      mosi_sync  <= '0;
      cs_sync    <= '1;  // deselected
      sck_q      <= 1'b0;
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
    end else begin
      sck_sync   <= {sck_sync[SYNC-2:0], sck};
      mosi_sync  <= {mosi_sync[SYNC-2:0], mosi};
      cs_sync    <= {cs_sync[SYNC-2:0], cs_n};
      sck_q      <= sck_sync[SYNC-1];
      byte_valid <= 1'b0;

      if (!active)
        bit_cnt <= 3'd0;  // realign on every deselect
      else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7)
          byte_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && sck_rise)
      rx_byte <= {rx_byte[6:0], mosi_sync[SYNC-1]};  // msb first

    if (active && sck_fall) begin
      // bit 7 went out in the first phase, before the reply was known
      if (bit_cnt == 3'd1)
        tx_shift <= {tx_byte[6:0], 1'b0};
      else
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = active & tx_shift[7];

endmodule

//--- spi_link/cmd_parser.sv
`timescale 1ns/1ps
`include "trs_io_config.svh"

module cmd_parser (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [7:0]              rx_byte,
  input  logic                    byte_valid,
  input  trs_io_pkg::z80_bus_t    bus,
  input  logic [3:0]              conf,
  input  logic [7:0]              flash_rx,
  output logic [7:0]              tx_byte,
  output trs_io_pkg::cmd_action_t action,
  output trs_io_pkg::flash_req_t  link_flash,
  output logic                    led_red,
  output logic                    led_green,
  output logic                    led_blue
);
  import trs_io_pkg::*;

  parser_state_t state;
  cmd_op_t       pending_op;  // opcode waiting for its parameter
  cmd_op_t       rx_op;
  logic [2:0]    led_reg;
  logic          led_set;     // host has taken over the blue led
  logic          esp_ready;   // esp status bit 0
  logic [7:0]    reply;

  assign rx_op = cmd_op_t'(rx_byte);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= idle;
      pending_op <= get_cookie;
      action     <= '0;
    end else begin
      action.valid <= 1'b0;
      if (byte_valid) begin
        case (state)
          idle: begin
            case (rx_op)
              get_cookie, dbus_read, get_version, abus_read, get_config, get_spi_data:
                action <= '{valid: 1'b1, op: rx_op, param: 8'h00};
              dbus_write, set_led, set_spi_ctrl_reg, set_spi_data, set_esp_status: begin
                pending_op <= rx_op;
                state      <= read_param;
              end
              default: state <= idle;  // unknown opcode dropped
            endcase
          end
          read_param: begin
            action <= '{valid: 1'b1, op: pending_op, param: rx_byte};
            state  <= idle;
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_comb begin
    case (action.op)
      get_cookie:   reply = `TRS_IO_COOKIE;
      get_version:  reply = {`TRS_IO_VERSION_MAJOR, `TRS_IO_VERSION_MINOR};
      get_config:   reply = {4'b0000, ~conf};  // switches are active low
      dbus_read:    reply = bus.data;
      abus_read:    reply = bus.addr[7:0];
      get_spi_data: reply = flash_rx;
      default:      reply = tx_byte;  // writes leave the last reply
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_byte   <= 8'h00;
      led_reg   <= 3'b000;
      led_set   <= 1'b0;
      esp_ready <= 1'b0;
    end else if (action.valid) begin
      tx_byte <= reply;
      if (action.op == set_led) begin
        led_reg <= action.param[2:0];
        led_set <= 1'b1;
      end
      if (action.op == set_esp_status)
        esp_ready <= action.param[0];
    end
  end

  assign link_flash.ctrl_we = action.valid && (action.op == set_spi_ctrl_reg);
  assign link_flash.data_we = action.valid && (action.op == set_spi_data);
  assign link_flash.ctrl    = action.param;
  assign link_flash.data    = action.param;

  assign led_red   = led_reg[0];
  assign led_green = led_reg[1];
  assign led_blue  = led_set ? led_reg[2] : esp_ready;  // ready indicator until set_led

endmodule

//--- hdl/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top (
  input  logic                   clk,
  input  logic                   reset,
  input  trs_io_pkg::z80_bus_t   bus,
  output logic [7:0]             d_out,
  output logic                   d_oe,
  output logic                   wait_out,
  output logic                   esp_req,
  output trs_io_pkg::esp_op_t    esp_s,
  input  logic                   esp_done,
  input  logic                   sck,
  input  logic                   mosi,
  input  logic                   cs_n,
  output logic                   miso,
  input  logic [3:0]             conf,
  output logic                   led_red,
  output logic                   led_green,
  output logic                   led_blue,
  output logic                   flash_cs_n,
  output logic                   flash_sck,
  output logic                   flash_si,
  input  logic                   flash_so
);
  import trs_io_pkg::*;

  logic [7:0]  rx_byte;
  logic        byte_valid;
  logic [7:0]  tx_byte;
  cmd_action_t action;
  flash_req_t  link_flash;
  flash_req_t  z80_flash;
  logic [7:0]  flash_rx;   // shared by the z80 read mux and the link reply

  z80_bus_decoder u_decoder (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus),
    .action    (action),
    .flash_rx  (flash_rx),
    .esp_done  (esp_done),
    .d_out     (d_out),
    .d_oe      (d_oe),
    .wait_out  (wait_out),
    .esp_req   (esp_req),
    .esp_s     (esp_s),
    .z80_flash (z80_flash)
  );

  spi_link_slave u_link (
    .clk        (clk),
    .reset      (reset),
    .sck        (sck),
    .mosi       (mosi),
    .cs_n       (cs_n),
    .miso       (miso),
    .tx_byte    (tx_byte),
    .rx_byte    (rx_byte),
    .byte_valid (byte_valid)
  );

  cmd_parser u_parser (
    .clk        (clk),
    .reset      (reset),
    .rx_byte    (rx_byte),
    .byte_valid (byte_valid),
    .bus        (bus),
    .conf       (conf),
    .flash_rx   (flash_rx),
    .tx_byte    (tx_byte),
    .action     (action),
    .link_flash (link_flash),
    .led_red    (led_red),
    .led_green  (led_green),
    .led_blue   (led_blue)
  );

  flash_spi_master u_flash (
    .clk        (clk),
    .reset      (reset),
    .z80_req    (z80_flash),
    .link_req   (link_flash),
    .flash_rx   (flash_rx),
    .flash_cs_n (flash_cs_n),
    .flash_sck  (flash_sck),
    .flash_si   (flash_si),
    .flash_so   (flash_so)
  );

endmodule

//--- tests/trs_io_properties.sv
`timescale 1ns/1ps
`include "trs_io_config.svh"

module trs_io_properties (
  input logic clk,
  input logic reset,
  input logic wait_out,
  input logic esp_req,
  input logic esp_done,
  input logic flash_sck,
  input logic xfer_start
);

  localparam int REQ_CYCLES  = `TRS_IO_ESP_REQ_CYCLES;
  localparam int XFER_CYCLES = 8 * `TRS_IO_FLASH_BIT_CYCLES;

  int xfer_left;  // clocks left in the running flash transfer

  always_ff @(posedge clk) begin
    if (reset)
      xfer_left <= 0;
    else if (xfer_start)
      xfer_left <= XFER_CYCLES;
    else if (xfer_left != 0)
      xfer_left <= xfer_left - 1;
  end

  // only the co-processor releases the z80, three clocks after its done edge
  wait_release: assert property (@(posedge clk) disable iff (reset)
    $fell(wait_out) |-> $past(esp_done, 3) && !$past(esp_done, 4))
    else $error("wait_out fell without a done edge from the co-processor");

  req_length: assert property (@(posedge clk) disable iff (reset)
    $fell(esp_req) |-> $past(esp_req, REQ_CYCLES) && !$past(esp_req, REQ_CYCLES + 1))
    else $error("esp_req pulse length differs from the request cycle count");

  sck_idle: assert property (@(posedge clk) disable iff (reset)
    (xfer_left == 0) |-> !flash_sck)
    else $error("flash_sck high with no transfer running");

endmodule

// the unused checks of each binding see constant inputs
bind z80_bus_decoder trs_io_properties u_bus_props (
  .clk(clk), .reset(reset), .wait_out(wait_out), .esp_req(esp_req),
  .esp_done(esp_done), .flash_sck(1'b0), .xfer_start(1'b0)
);

bind flash_spi_master trs_io_properties u_flash_props (
  .clk(clk), .reset(reset), .wait_out(1'b0), .esp_req(1'b0),
  .esp_done(1'b0), .flash_sck(flash_sck), .xfer_start(req.data_we & ~busy)
);

//--- tests/trs_io_tb.sv
`timescale 1ns/1ps
`include "trs_io_config.svh"

module trs_io_tb;
  import trs_io_pkg::*;

  localparam int SPI_HALF    = 6;    // clocks per sck phase
  localparam int WAIT_LIMIT  = 200;
  localparam int FLASH_LIMIT = 32 * `TRS_IO_FLASH_BIT_CYCLES;

  logic       clk;
  logic       reset;
  z80_bus_t   bus;
  logic [7:0] d_out;
  logic       d_oe;
  logic       wait_out;
  logic       esp_req;
  esp_op_t    esp_s;
  logic       esp_done;
  logic       sck;
  logic       mosi;
  logic       cs_n;
  logic       miso;
  logic [3:0] conf;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       flash_cs_n;
  logic       flash_sck;
  logic       flash_si;
  logic       flash_so;

  // flash device model
  logic [7:0] so_pattern;
  logic [7:0] si_bits;
  logic       so_bit;
  logic       sck_seen;
  int         rise_cnt;

  logic             esp_pending;  // z80 cycle held in wait
  logic             led_taken;
  logic [8*16-1:0]  op;
  logic [8*128-1:0] line;
  logic [7:0]       a;
  logic [7:0]       b;
  logic [7:0]       c;
  int               fd;
  int               code;
  int               rec;

  trs_io_top DUT (.*);

  always #5 clk = ~clk;

  always @(posedge clk) flash_so <= so_bit;

  always @(negedge clk) begin
    if (flash_sck && !sck_seen && rise_cnt < 8) begin
      si_bits  = {si_bits[6:0], flash_si};
      rise_cnt = rise_cnt + 1;
    end else if (!flash_sck && sck_seen && rise_cnt < 8)
      so_bit = so_pattern[3'(7 - rise_cnt)];  // next bit while sck is low
    sck_seen = flash_sck;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_esp_op(input esp_op_t got, input esp_op_t exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch esp_s: got %h, expected %h", got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic idle_gap(input int min_clocks);
    repeat (min_clocks + int'($urandom % 8)) @(posedge clk);
  endtask

  task automatic wait_for_wait_out(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (wait_out !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (wait_out !== level)
      fail_run($sformatf("timeout while waiting for wait_out to go to %0d", level));
  endtask

  // one request pulse per bus cycle, so let the last one end first
  task automatic wait_req_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (esp_req !== 1'b0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (esp_req !== 1'b0)
      fail_run("timeout while waiting for esp_req to end");
  endtask

  task automatic arm_flash(input logic [7:0] pattern);
    so_pattern = pattern;
    so_bit     = pattern[7];
    si_bits    = 8'h00;
    rise_cnt   = 0;
  endtask

  task automatic wait_flash_rises();
    int n;
    n = 0;
    while (rise_cnt < 8 && n < FLASH_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (rise_cnt < 8)
      fail_run("timeout while waiting for eight flash clock pulses");
    repeat (`TRS_IO_FLASH_BIT_CYCLES) @(posedge clk);  // last sample and wrap
  endtask

  function automatic logic is_esp_port(input logic [7:0] port);
    return (port == `TRS_IO_PORT) || (port[7:4] == `TRS_IO_FREHD_NIBBLE);
  endfunction

  task automatic end_cycle();
    @(posedge clk);
    bus.in_n  <= 1'b1;
    bus.out_n <= 1'b1;
    idle_gap(4);
  endtask

  task automatic z80_access(input logic [7:0] port, input logic [7:0] data,
                            input logic is_in, input logic [7:0] exp_val);
    logic    esp;
    logic    readable;
    esp_op_t exp_op;
    esp      = is_esp_port(port);
    readable = is_in && (esp || port == `TRS_IO_SPI_DATA_PORT);
    if (port == `TRS_IO_PORT)
      exp_op = is_in ? trs_io_in : trs_io_out;
    else
      exp_op = is_in ? frehd_in : frehd_out;
    wait_req_idle();
    @(posedge clk);
    bus.addr <= {8'h00, port};
    bus.data <= data;
    if (is_in)
      bus.in_n <= 1'b0;
    else
      bus.out_n <= 1'b0;
    if (esp) begin
      wait_for_wait_out(1'b1);
      check_bit("esp_req", esp_req, 1'b1);
      check_esp_op(esp_s, exp_op);
    end else begin
      repeat (8) @(posedge clk);
      @(negedge clk);
      check_bit("wait_out", wait_out, 1'b0);
      check_bit("esp_req", esp_req, 1'b0);
      check_esp_op(esp_s, none);
    end
    check_bit("d_oe", d_oe, readable);
    if (readable)
      check_byte("d_out", d_out, exp_val);
    if (esp)
      esp_pending = 1'b1;  // released by the esp_done record
    else
      end_cycle();
    if (!is_in && port == `TRS_IO_SPI_CTRL_PORT) begin
      @(negedge clk);
      check_bit("flash_cs_n", flash_cs_n, ~data[7]);
    end
  endtask

  task automatic finish_esp();
    if (!esp_pending)
      fail_run("esp_done record found with no bus cycle waiting");
    @(posedge clk) esp_done <= 1'b1;
    wait_for_wait_out(1'b0);
    @(posedge clk) esp_done <= 1'b0;
    end_cycle();
    esp_pending = 1'b0;
  endtask

  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    rx = 8'h00;
    @(posedge clk) cs_n <= 1'b0;
    repeat (4) @(posedge clk);
    for (i = 7; i >= 0; i--) begin
      @(posedge clk);
      sck  <= 1'b0;
      mosi <= tx[i];
      repeat (SPI_HALF) @(posedge clk);
      @(negedge clk);
      rx = {rx[6:0], miso};  // first sample is stale
      @(posedge clk);
      sck <= 1'b1;
      repeat (SPI_HALF) @(posedge clk);
    end
    @(posedge clk) sck <= 1'b0;
    repeat (4) @(posedge clk);
    cs_n <= 1'b1;
    idle_gap(40);
  endtask

  task automatic spi_cmd(input logic [7:0] opcode, input logic [7:0] param,
                         input logic [7:0] exp_val);
    logic [7:0] rx;
    logic       has_param;
    logic       is_read;
    has_param = opcode inside {dbus_write, set_led, set_spi_ctrl_reg, set_spi_data,
                               set_esp_status};
    is_read   = opcode inside {get_cookie, dbus_read, get_version, abus_read, get_config,
                               get_spi_data};
    if (opcode == dbus_read)
      @(posedge clk) bus.data <= param;
    if (opcode == abus_read)
      @(posedge clk) bus.addr <= {8'h00, param};
    if (opcode == set_spi_data)
      arm_flash(exp_val);  // byte the flash sends back
    spi_byte(opcode, rx);
    if (has_param)
      spi_byte(param, rx);
    if (is_read) begin
      spi_byte(8'h00, rx);
      check_byte("miso reply", {1'b0, rx[6:0]}, {1'b0, exp_val[6:0]});
    end
    @(negedge clk);
    if (opcode == set_led) begin
      check_bit("led_red", led_red, param[0]);
      check_bit("led_green", led_green, param[1]);
      check_bit("led_blue", led_blue, param[2]);
      led_taken = 1'b1;
    end
    if (opcode == set_esp_status && !led_taken)
      check_bit("led_blue", led_blue, param[0]);
    if (opcode == set_spi_ctrl_reg)
      check_bit("flash_cs_n", flash_cs_n, ~param[7]);
    if (opcode == set_spi_data) begin
      wait_flash_rises();
      check_byte("flash_si", si_bits, param);
    end
  endtask

  task automatic flash_xfer(input logic [7:0] data, input logic [7:0] so, input logic rnd);
    logic [7:0] pattern;
    pattern = rnd ? 8'($urandom) : so;
    arm_flash(pattern);
    z80_access(`TRS_IO_SPI_DATA_PORT, data, 1'b0, 8'h00);
    wait_flash_rises();
    check_byte("flash_si", si_bits, data);
    z80_access(`TRS_IO_SPI_DATA_PORT, 8'h00, 1'b1, pattern);
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    bus         = '{addr: 16'h0000, data: 8'h00, rd_n: 1'b1, wr_n: 1'b1,
                    in_n: 1'b1, out_n: 1'b1};
    esp_done    = 1'b0;
    sck         = 1'b0;
    mosi        = 1'b0;
    cs_n        = 1'b1;
    conf        = 4'hA;  // board switches
    flash_so    = 1'b0;
    so_bit      = 1'b0;
    sck_seen    = 1'b0;
    esp_pending = 1'b0;
    led_taken   = 1'b0;
    rec         = 0;
    arm_flash(8'h00);
    void'($urandom(32'he9d2));

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("wait_out", wait_out, 1'b0);
    check_bit("esp_req", esp_req, 1'b0);
    check_bit("d_oe", d_oe, 1'b0);
    check_bit("flash_cs_n", flash_cs_n, 1'b1);
    check_esp_op(esp_s, none);
    check_byte("leds", {5'b00000, led_blue, led_green, led_red}, 8'h00);

    fd = $fopen("tests/trs_io_testdata.txt", "r");
    if (fd == 0)
      fail_run("cannot open tests/trs_io_testdata.txt");
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1)
        break;
      if (op == "#")
        code = $fgets(line, fd);  // comment line
      else begin
        code = $fscanf(fd, "%h %h %h", a, b, c);
        if (code != 3)
          fail_run($sformatf("record %0d of the test data has missing fields", rec));
        case (op)
          "z80_in":   z80_access(a, 8'h00, 1'b1, b);
          "z80_out":  z80_access(a, b, 1'b0, 8'h00);
          "spi_cmd":  spi_cmd(a, b, c);
          "esp_done": finish_esp();
          "flash":    flash_xfer(a, b, c[0]);
          default:    fail_run($sformatf("record %0d has an unknown kind", rec));
        endcase
        rec++;
      end
    end
    $fclose(fd);
    if (esp_pending)
      fail_run("test data ends with a bus cycle still in wait");
    else if (rec == 0)
      fail_run("test data holds no records");
    else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+common
common/trs_io_pkg.sv
hdl/z80_bus_decoder.sv
hdl/flash_spi_master.sv
spi_link/spi_link_slave.sv
spi_link/cmd_parser.sv
hdl/trs_io_top.sv
tests/trs_io_properties.sv
tests/trs_io_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module trs_io_tb -o trs_io_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/trs_io_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

//--- tests/trs_io_testdata.txt
# columns: kind a b c, values in hex
# z80_in port data | z80_out port data 00 | spi_cmd opcode param reply | esp_done | flash si so rnd
spi_cmd 00 00 af
spi_cmd 0f 00 03
spi_cmd 1b 00 05
spi_cmd 20 01 00
spi_cmd 04 5a 00
# esp ports hold the bus until the co-processor is done
z80_in 1f 5a 00
esp_done 00 00 00
z80_out 1f 33 00
esp_done 00 00 00
z80_in c7 5a 00
esp_done 00 00 00
z80_out cc 12 00
esp_done 00 00 00
z80_in 40 00 00
z80_out 7e 00 00
spi_cmd 03 c3 c3
spi_cmd 12 a5 a5
spi_cmd 1a 05 00
spi_cmd 1a 02 00
# flash master, first from the z80, then from the host
z80_out fc 80 00
flash 9c 6b 00
flash 31 00 01
spi_cmd 1e e7 4d
spi_cmd 1f 00 4d
spi_cmd 1d 00 00
spi_cmd 63 00 00
spi_cmd 00 00 af
